// ==== Makefile ====
# Verilator build and run of the AXI subsystem testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_axi_subsys
FILELIST  ?= compile.f

OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: sim clean

# The run passes only when the log holds the pass message.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axi_master/axi_rd_engine.sv ====
module axi_rd_engine (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       cs_i,
    input  logic                       we_i,
    input  logic [axi_pkg::ADDR_W-1:0] addr_i,
    output logic                       rd_busy_o,
    output axi_pkg::ar_req_t           ar_req_o,
    output logic                       ar_valid_o,
    input  logic                       ar_ready_i,
    input  axi_pkg::r_beat_t           r_beat_i,
    input  logic                       r_valid_i,
    output logic                       r_ready_o,
    output logic [axi_pkg::LINE_W-1:0] rdata_o,
    output logic                       rvalid_o,
    output logic                       rd_err_o
);
    import axi_pkg::*;

    rd_state_e         state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [BEAT_W-1:0] beat_q;
    logic              err_q;
    logic              beat_err;
    logic [LINE_W-1:0] line_q;
    logic [LINE_W-1:0] line_d;

    assign rd_busy_o  = (state_q != RD_IDLE);
    assign ar_valid_o = (state_q == RD_ADDR);
    assign r_ready_o  = (state_q == RD_DATA);
    assign beat_err   = (r_beat_i.resp != RESP_OKAY);

    always_comb begin
        ar_req_o.addr  = addr_q;
        ar_req_o.size  = AXI_SIZE;
        ar_req_o.len   = LEN_LINE;
        ar_req_o.burst = BURST_INCR;
        ar_req_o.id    = ID_CPU2MEM;
        case (addr_region(addr_q))
            REG_DMA: ar_req_o.id = ID_CPU2DMA;
            REG_AES: begin
                ar_req_o.id    = ID_CPU2AES;
                ar_req_o.len   = LEN_SINGLE;
                ar_req_o.burst = BURST_FIXED;
            end
            default: ;
        endcase
    end

    // Line with the incoming beat dropped into its slot.
    always_comb begin
        line_d = line_q;
        line_d[beat_q*DATA_W +: DATA_W] = r_beat_i.data;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q  <= RD_IDLE;
            beat_q   <= '0;
            err_q    <= 1'b0;
            rvalid_o <= 1'b0;
            rd_err_o <= 1'b0;
        end else begin
            rvalid_o <= 1'b0;
            rd_err_o <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (cs_i && !we_i) begin
                        state_q <= RD_ADDR;
                        beat_q  <= '0;
                        err_q   <= 1'b0;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready_i)
                        state_q <= RD_DATA;
                end
                RD_DATA: begin
                    if (r_valid_i) begin
                        beat_q <= beat_q + 1'b1;
                        err_q  <= err_q | beat_err;
                        if (r_beat_i.last) begin
                            state_q  <= RD_IDLE;
                            rvalid_o <= 1'b1;
                            rd_err_o <= err_q | beat_err;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // Slots above a single beat stay zero.
    always_ff @(posedge clk_i) begin
        if (state_q == RD_IDLE && cs_i && !we_i) begin
            addr_q <= addr_i;
            line_q <= '0;
        end else if (r_valid_i && r_ready_o) begin
            line_q <= line_d;
            if (r_beat_i.last)
                rdata_o <= line_d;
        end
    end

    a_r_beat_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i && r_ready_o |-> r_beat_i.last == (LEN_W'(beat_q) == ar_req_o.len))
        else $error("R burst length differs from the requested length");

endmodule

// ==== axi_master/axi_wr_engine.sv ====
module axi_wr_engine (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              cs_i,
    input  logic              we_i,
    input  axi_pkg::cpu_req_t req_i,
    output logic              wr_full_o,
    output axi_pkg::aw_req_t  aw_req_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output axi_pkg::w_beat_t  w_beat_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  axi_pkg::b_resp_t  b_resp_i,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    output logic              wr_done_o,
    output logic              wr_err_o
);
    import axi_pkg::*;

    wr_state_e         state_q;
    cpu_req_t          head;
    cpu_req_t          line_q;
    logic              push;
    logic              pop;
    logic              fifo_empty;
    logic [BEAT_W-1:0] beat_q;

    // Writes are dropped while the queue is full.
    assign push      = cs_i && we_i && !wr_full_o;
    assign pop       = (state_q == WR_IDLE) && !fifo_empty;

    sync_fifo u_fifo (
        .clk_i,
        .rst_ni,
        .push_i  (push),
        .pop_i   (pop),
        .data_i  (req_i),
        .data_o  (head),
        .full_o  (wr_full_o),
        .empty_o (fifo_empty)
    );

    always_comb begin
        aw_req_o.addr  = line_q.addr;
        aw_req_o.size  = AXI_SIZE;
        aw_req_o.len   = LEN_LINE;
        aw_req_o.burst = BURST_INCR;
        aw_req_o.id    = ID_CPU2MEM;
        case (addr_region(line_q.addr))
            REG_DMA: aw_req_o.id = ID_CPU2DMA;
            REG_AES: begin
                aw_req_o.id    = ID_CPU2AES;
                aw_req_o.len   = LEN_SINGLE;
                aw_req_o.burst = BURST_FIXED;
            end
            default: ;
        endcase
    end

    assign aw_valid_o    = (state_q == WR_ADDR);
    assign w_valid_o     = (state_q == WR_DATA);
    assign b_ready_o     = (state_q == WR_RESP);
    assign w_beat_o.data = line_q.data[beat_q*DATA_W +: DATA_W];
    assign w_beat_o.strb = '1;
    assign w_beat_o.last = (LEN_W'(beat_q) == aw_req_o.len);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q   <= WR_IDLE;
            beat_q    <= '0;
            wr_done_o <= 1'b0;
            wr_err_o  <= 1'b0;
        end else begin
            wr_done_o <= 1'b0;
            wr_err_o  <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (pop) begin
                        state_q <= WR_ADDR;
                        beat_q  <= '0;
                    end
                end
                WR_ADDR: begin
                    if (aw_ready_i)
                        state_q <= WR_DATA;
                end
                WR_DATA: begin
                    if (w_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (w_beat_o.last)
                            state_q <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_valid_i) begin
                        state_q   <= WR_IDLE;
                        wr_done_o <= 1'b1;
                        wr_err_o  <= (b_resp_i.resp != RESP_OKAY);
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Head line is captured as it leaves the queue.
    always_ff @(posedge clk_i) begin
        if (pop)
            line_q <= head;
    end

    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_req_o))
        else $error("AW request changed before the handshake");

endmodule

// ==== common/axi_pkg.sv ====
package axi_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_W     = 128;
    localparam int BEATS      = 4;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int MEM_WORDS  = 256;

    localparam int STRB_W     = DATA_W / 8;
    localparam int WORD_LSB   = $clog2(STRB_W);
    localparam int MEM_AW     = $clog2(MEM_WORDS);
    localparam int BEAT_W     = $clog2(BEATS);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam logic [2:0]       AXI_SIZE    = 3'(WORD_LSB);
    localparam logic [1:0]       BURST_FIXED = 2'b00;
    localparam logic [1:0]       BURST_INCR  = 2'b01;
    localparam logic [LEN_W-1:0] LEN_LINE    = LEN_W'(BEATS - 1);
    localparam logic [LEN_W-1:0] LEN_SINGLE  = '0;

    typedef enum logic [1:0] {
        REG_MEM  = 2'd0,
        REG_DMA  = 2'd1,
        REG_AES  = 2'd2,
        REG_NONE = 2'd3
    } region_e;

    typedef enum logic [ID_W-1:0] {
        ID_CPU2MEM = 4'd0,
        ID_CPU2DMA = 4'd1,
        ID_CPU2AES = 4'd2
    } axi_id_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] data;
    } cpu_req_t;

    typedef struct packed {
        axi_id_e           id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } aw_req_t;

    // AR carries the same fields as AW.
    typedef aw_req_t ar_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        axi_id_e id;
        resp_e   resp;
    } b_resp_t;

    typedef struct packed {
        axi_id_e           id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } r_beat_t;

    function automatic region_e addr_region(input logic [ADDR_W-1:0] addr);
        case (addr[19:16])
            4'h0:    return REG_MEM;
            4'h1:    return REG_DMA;
            4'h2:    return REG_AES;
            default: return REG_NONE;
        endcase
    endfunction

endpackage

// ==== compile.f ====
common/axi_pkg.sv
design/sync_fifo.sv
axi_master/axi_wr_engine.sv
axi_master/axi_rd_engine.sv
design/axi_mem_target.sv
design/axi_subsys_top.sv
verif/tb_axi_subsys.sv

// ==== design/axi_mem_target.sv ====
module axi_mem_target (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  axi_pkg::aw_req_t aw_req_i,
    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  axi_pkg::w_beat_t w_beat_i,
    input  logic             w_valid_i,
    output logic             w_ready_o,
    output axi_pkg::b_resp_t b_resp_o,
    output logic             b_valid_o,
    input  logic             b_ready_i,
    input  axi_pkg::ar_req_t ar_req_i,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    output axi_pkg::r_beat_t r_beat_o,
    output logic             r_valid_o,
    input  logic             r_ready_i
);
    import axi_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] aes_q;

    // w_ready_o marks an open write burst, r_valid_o an open read burst.
    axi_id_e           wr_id_q;
    region_e           wr_region_q;
    logic              wr_incr_q;
    logic [LEN_W-1:0]  wr_len_q;
    logic [LEN_W-1:0]  wr_cnt_q;
    logic [MEM_AW-1:0] wr_ptr_q;
    logic              w_fire;
    logic              w_done;

    axi_id_e           rd_id_q;
    region_e           rd_region_q;
    logic              rd_incr_q;
    logic [LEN_W-1:0]  rd_len_q;
    logic [LEN_W-1:0]  rd_cnt_q;
    logic [MEM_AW-1:0] rd_ptr_q;
    logic [MEM_AW-1:0] rd_next_ptr;
    logic [DATA_W-1:0] rd_data_q;
    logic              r_fire;

    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old_word,
                                                input w_beat_t beat);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (beat.strb[i])
                word[8*i +: 8] = beat.data[8*i +: 8];
        end
        return word;
    endfunction

    // Unmapped regions read as zero.
    function automatic logic [DATA_W-1:0] read_word(input region_e region,
                                                    input logic [MEM_AW-1:0] idx);
        case (region)
            REG_MEM, REG_DMA: return mem[idx];
            REG_AES:          return aes_q;
            default:          return '0;
        endcase
    endfunction

    assign w_fire      = w_valid_i && w_ready_o;
    assign w_done      = w_fire && (wr_cnt_q == wr_len_q);
    assign r_fire      = r_valid_o && r_ready_i;
    assign rd_next_ptr = rd_incr_q ? rd_ptr_q + 1'b1 : rd_ptr_q;

    assign b_resp_o.id   = wr_id_q;
    assign b_resp_o.resp = (wr_region_q == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
    assign r_beat_o.id   = rd_id_q;
    assign r_beat_o.data = rd_data_q;
    assign r_beat_o.resp = (rd_region_q == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
    assign r_beat_o.last = (rd_cnt_q == rd_len_q);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
        end else begin
            // Address ready returns once the B transfer closes the burst.
            if (aw_ready_o)
                aw_ready_o <= !aw_valid_i;
            else
                aw_ready_o <= (!w_ready_o && !b_valid_o) || (b_valid_o && b_ready_i);
            if (aw_valid_i && aw_ready_o)
                w_ready_o <= 1'b1;
            else if (w_done)
                w_ready_o <= 1'b0;
            if (w_done)
                b_valid_o <= 1'b1;
            else if (b_ready_i)
                b_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_valid_i && aw_ready_o) begin
            wr_id_q     <= aw_req_i.id;
            wr_region_q <= addr_region(aw_req_i.addr);
            wr_incr_q   <= (aw_req_i.burst == BURST_INCR);
            wr_len_q    <= aw_req_i.len;
            wr_cnt_q    <= '0;
            wr_ptr_q    <= aw_req_i.addr[WORD_LSB +: MEM_AW];
        end else if (w_fire) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
            if (wr_incr_q)
                wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_fire && (wr_region_q == REG_MEM || wr_region_q == REG_DMA))
            mem[wr_ptr_q] <= merge(mem[wr_ptr_q], w_beat_i);
        if (w_fire && wr_region_q == REG_AES)
            aes_q <= merge(aes_q, w_beat_i);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
        end else begin
            if (ar_ready_o)
                ar_ready_o <= !ar_valid_i;
            else
                ar_ready_o <= !r_valid_o || (r_fire && r_beat_o.last);
            if (ar_valid_i && ar_ready_o)
                r_valid_o <= 1'b1;
            else if (r_fire && r_beat_o.last)
                r_valid_o <= 1'b0;
        end
    end

    // Beat data is registered so it holds under back-pressure.
    always_ff @(posedge clk_i) begin
        if (ar_valid_i && ar_ready_o) begin
            rd_id_q     <= ar_req_i.id;
            rd_region_q <= addr_region(ar_req_i.addr);
            rd_incr_q   <= (ar_req_i.burst == BURST_INCR);
            rd_len_q    <= ar_req_i.len;
            rd_cnt_q    <= '0;
            rd_ptr_q    <= ar_req_i.addr[WORD_LSB +: MEM_AW];
            rd_data_q   <= read_word(addr_region(ar_req_i.addr),
                                     ar_req_i.addr[WORD_LSB +: MEM_AW]);
        end else if (r_fire && !r_beat_o.last) begin
            rd_cnt_q  <= rd_cnt_q + 1'b1;
            rd_ptr_q  <= rd_next_ptr;
            rd_data_q <= read_word(rd_region_q, rd_next_ptr);
        end
    end

    a_wlast_at_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_fire |-> w_beat_i.last == (wr_cnt_q == wr_len_q))
        else $error("WLAST does not match the AW burst length");

endmodule

// ==== design/axi_subsys_top.sv ====
module axi_subsys_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  axi_pkg::cpu_req_t          req_i,
    input  logic                       cs_i,
    input  logic                       we_i,
    output logic                       wr_full_o,
    output logic                       wr_done_o,
    output logic                       wr_err_o,
    output logic                       rd_busy_o,
    output logic [axi_pkg::LINE_W-1:0] rdata_o,
    output logic                       rvalid_o,
    output logic                       rd_err_o
);
    import axi_pkg::*;

    aw_req_t aw_req;
    logic    aw_valid;
    logic    aw_ready;
    w_beat_t w_beat;
    logic    w_valid;
    logic    w_ready;
    b_resp_t b_resp;
    logic    b_valid;
    logic    b_ready;
    ar_req_t ar_req;
    logic    ar_valid;
    logic    ar_ready;
    r_beat_t r_beat;
    logic    r_valid;
    logic    r_ready;

    axi_wr_engine u_wr_engine (
        .clk_i,
        .rst_ni,
        .cs_i,
        .we_i,
        .req_i,
        .wr_full_o,
        .aw_req_o   (aw_req),
        .aw_valid_o (aw_valid),
        .aw_ready_i (aw_ready),
        .w_beat_o   (w_beat),
        .w_valid_o  (w_valid),
        .w_ready_i  (w_ready),
        .b_resp_i   (b_resp),
        .b_valid_i  (b_valid),
        .b_ready_o  (b_ready),
        .wr_done_o,
        .wr_err_o
    );

    axi_rd_engine u_rd_engine (
        .clk_i,
        .rst_ni,
        .cs_i,
        .we_i,
        .addr_i     (req_i.addr),
        .rd_busy_o,
        .ar_req_o   (ar_req),
        .ar_valid_o (ar_valid),
        .ar_ready_i (ar_ready),
        .r_beat_i   (r_beat),
        .r_valid_i  (r_valid),
        .r_ready_o  (r_ready),
        .rdata_o,
        .rvalid_o,
        .rd_err_o
    );

    axi_mem_target u_target (
        .clk_i,
        .rst_ni,
        .aw_req_i   (aw_req),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_beat_i   (w_beat),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_resp_o   (b_resp),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .ar_req_i   (ar_req),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_beat_o   (r_beat),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready)
    );

endmodule

// ==== design/sync_fifo.sv ====
module sync_fifo (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push_i,
    input  logic              pop_i,
    input  axi_pkg::cpu_req_t data_i,
    output axi_pkg::cpu_req_t data_o,
    output logic              full_o,
    output logic              empty_o
);
    import axi_pkg::*;

    cpu_req_t            mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0] wr_ptr_q;
    logic [FIFO_PTR_W:0] rd_ptr_q;

    // Extra pointer bit tells a full buffer from an empty one.
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[FIFO_PTR_W] != rd_ptr_q[FIFO_PTR_W]) &&
                     (wr_ptr_q[FIFO_PTR_W-1:0] == rd_ptr_q[FIFO_PTR_W-1:0]);
    assign data_o  = mem[rd_ptr_q[FIFO_PTR_W-1:0]];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i)
            mem[wr_ptr_q[FIFO_PTR_W-1:0]] <= data_i;
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(push_i && full_o))
        else $error("push into full FIFO");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_i && empty_o))
        else $error("pop from empty FIFO");

endmodule

// ==== verif/tb_axi_subsys.sv ====
module tb_axi_subsys;
    import axi_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst_n;
    logic              cs;
    logic              we;
    cpu_req_t          req;
    logic              wr_full;
    logic              wr_done;
    logic              wr_err;
    logic              rd_busy;
    logic [LINE_W-1:0] rdata;
    logic              rvalid;
    logic              rd_err;

    // Reference model of the target storage.
    logic [DATA_W-1:0] exp_mem [256];
    logic [DATA_W-1:0] exp_aes;
    logic [LINE_W-1:0] exp_rdata;
    logic              exp_rerr;
    logic              exp_werr;

    integer seed;
    string  test_name;
    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    int     done_count;
    int     rvalid_count;

    axi_subsys_top dut (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .req_i     (req),
        .cs_i      (cs),
        .we_i      (we),
        .wr_full_o (wr_full),
        .wr_done_o (wr_done),
        .wr_err_o  (wr_err),
        .rd_busy_o (rd_busy),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rd_err_o  (rd_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wr_done)
            done_count <= done_count + 1;
        if (rvalid)
            rvalid_count <= rvalid_count + 1;
    end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> rdata == exp_rdata)
        else begin
            $display("MISMATCH %s: rdata expected %h, actual %h",
                     test_name, $sampled(exp_rdata), $sampled(rdata));
            errors++;
        end

    a_read_err: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> rd_err == exp_rerr)
        else begin
            $display("MISMATCH %s: rd_err expected %b, actual %b",
                     test_name, $sampled(exp_rerr), $sampled(rd_err));
            errors++;
        end

    a_write_err: assert property (@(posedge clk) disable iff (!rst_n)
        wr_done |-> wr_err == exp_werr)
        else begin
            $display("MISMATCH %s: wr_err expected %b, actual %b",
                     test_name, $sampled(exp_werr), $sampled(wr_err));
            errors++;
        end

    task automatic check_value(input string what, input logic [LINE_W-1:0] exp,
                               input logic [LINE_W-1:0] act);
        assert (act == exp)
        else begin
            $display("MISMATCH %s (%s): expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: wait for %s expired", test_name, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic next_line(output logic [LINE_W-1:0] line);
        for (int i = 0; i < BEATS; i++)
            line[DATA_W*i +: DATA_W] = $random(seed);
    endtask

    // MEM and DMA share one word array indexed by address bits 9:2.
    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        logic [7:0] idx;
        idx = addr[9:2];
        if (addr[19:16] == 4'h2) begin
            exp_aes = line[DATA_W-1:0];
        end else if (addr[19:16] < 4'h2) begin
            for (int i = 0; i < BEATS; i++)
                exp_mem[idx + 8'(i)] = line[DATA_W*i +: DATA_W];
        end
    endtask

    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [7:0]        idx;
        line = '0;
        idx  = addr[9:2];
        if (addr[19:16] == 4'h2) begin
            line[DATA_W-1:0] = exp_aes;
        end else if (addr[19:16] < 4'h2) begin
            for (int i = 0; i < BEATS; i++)
                line[DATA_W*i +: DATA_W] = exp_mem[idx + 8'(i)];
        end
        return line;
    endfunction

    task automatic wait_not_full();
        int n;
        n = 0;
        while (wr_full) begin
            if (n == WAIT_LIMIT)
                report_timeout("wr_full_o to drop");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic wait_read_idle();
        int n;
        n = 0;
        while (rd_busy) begin
            if (n == WAIT_LIMIT)
                report_timeout("rd_busy_o to drop");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic wait_writes_done(input int target);
        int n;
        n = 0;
        while (done_count < target) begin
            if (n == WAIT_LIMIT)
                report_timeout("wr_done_o");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic wait_reads_done(input int target);
        int n;
        n = 0;
        while (rvalid_count < target) begin
            if (n == WAIT_LIMIT)
                report_timeout("rvalid_o");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic write_and_wait(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
        int target;
        wait_not_full();
        target   = done_count + 1;
        exp_werr = (addr[19:16] > 4'h2);
        model_write(addr, line);
        req.addr = addr;
        req.data = line;
        cs       = 1'b1;
        we       = 1'b1;
        @(posedge clk);
        #1;
        cs = 1'b0;
        we = 1'b0;
        wait_writes_done(target);
    endtask

    task automatic read_and_check(input logic [ADDR_W-1:0] addr);
        int target;
        wait_read_idle();
        target    = rvalid_count + 1;
        exp_rdata = expected_line(addr);
        exp_rerr  = (addr[19:16] > 4'h2);
        req.addr  = addr;
        cs        = 1'b1;
        we        = 1'b0;
        @(posedge clk);
        #1;
        cs = 1'b0;
        wait_reads_done(target);
    endtask

    initial begin
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] addr;
        logic [5:0]        taken;
        logic              full_seen;
        int                target;

        seed         = 32'hed7a_efab;
        rst_n        = 1'b0;
        cs           = 1'b0;
        we           = 1'b0;
        req          = '0;
        exp_rdata    = '0;
        exp_rerr     = 1'b0;
        exp_werr     = 1'b0;
        exp_aes      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_count   = 0;
        rvalid_count = 0;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset_state");
        check_value("status outputs", '0, {wr_full, wr_done, wr_err, rd_busy, rvalid, rd_err});
        check_value("axi valids", '0,
                    {dut.aw_valid, dut.w_valid, dut.b_valid, dut.ar_valid, dut.r_valid});
        finish_test();

        start_test("line_write_read");
        next_line(line);
        write_and_wait(32'h0000_0040, line);
        read_and_check(32'h0000_0040);
        next_line(line);
        write_and_wait(32'h0001_0080, line);
        read_and_check(32'h0001_0080);
        finish_test();

        start_test("aes_region");
        next_line(line);
        write_and_wait(32'h0002_0000, line);
        read_and_check(32'h0002_0000);
        finish_test();

        start_test("unmapped_region");
        next_line(line);
        write_and_wait(32'h0005_0100, line);
        read_and_check(32'h0005_0100);
        finish_test();

        // A write is taken when wr_full_o is low at the edge that samples it.
        start_test("queue_full");
        full_seen = 1'b0;
        taken     = '0;
        exp_werr  = 1'b0;
        target    = done_count;
        for (int k = 0; k < 6; k++) begin
            addr = 32'h0000_0100 + 32'(16 * k);
            next_line(line);
            req.addr = addr;
            req.data = line;
            cs       = 1'b1;
            we       = 1'b1;
            if (!wr_full) begin
                taken[k] = 1'b1;
                model_write(addr, line);
                target++;
            end else begin
                full_seen = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        cs = 1'b0;
        we = 1'b0;
        check_value("wr_full_o seen", 1, full_seen);
        // The first write leaves the queue at once, then four more fill it.
        check_value("writes taken", 128'(FIFO_DEPTH + 1), 128'($countones(taken)));
        wait_writes_done(target);
        repeat (20) @(posedge clk);
        #1;
        check_value("write completions", 128'(target), 128'(done_count));
        for (int k = 0; k < 6; k++) begin
            if (taken[k])
                read_and_check(32'h0000_0100 + 32'(16 * k));
        end
        finish_test();

        start_test("read_while_busy");
        wait_read_idle();
        target    = rvalid_count + 1;
        exp_rdata = expected_line(32'h0000_0040);
        exp_rerr  = 1'b0;
        req.addr  = 32'h0000_0040;
        cs        = 1'b1;
        we        = 1'b0;
        @(posedge clk);
        #1;
        check_value("rd_busy_o", 1, rd_busy);
        req.addr = 32'h0001_0080;
        @(posedge clk);
        #1;
        cs = 1'b0;
        wait_reads_done(target);
        repeat (20) @(posedge clk);
        #1;
        check_value("rvalid pulses", 128'(target), 128'(rvalid_count));
        finish_test();

        $display("Summary: %0d tests run, %0d tests failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
